/* logic/char_cell.sv */
`include "stat_display_cfg.svh"

module char_cell
    import display_pkg::*;
#(
    parameter logic [9:0] ORIGIN_ROW = '0,
    parameter logic [9:0] ORIGIN_COL = '0
) (
    input  vga_coord_t coord,
    input  logic [7:0] code,
    output logic       lit
);
    // scaled box, 10 wide by 14 high at scale 2
    localparam logic [9:0] END_ROW = ORIGIN_ROW + 10'(7 * `GLYPH_SCALE);
    localparam logic [9:0] END_COL = ORIGIN_COL + 10'(5 * `GLYPH_SCALE);

    logic       in_box;
    logic [9:0] d_row;
    logic [9:0] d_col;
    logic [2:0] font_row;
    logic [2:0] font_col;
    logic [4:0] bits;

    assign in_box = coord.row >= ORIGIN_ROW && coord.row < END_ROW &&
                    coord.col >= ORIGIN_COL && coord.col < END_COL;

    // offset inside the box, back to font units
    assign d_row    = coord.row - ORIGIN_ROW;
    assign d_col    = coord.col - ORIGIN_COL;
    assign font_row = 3'(d_row / 10'(`GLYPH_SCALE));
    assign font_col = 3'(d_col / 10'(`GLYPH_SCALE));

    glyph_rom u_rom (.code(code), .row(font_row), .bits(bits));

    always_comb begin
        lit = 1'b0;
        if (in_box) begin
            lit = bits[3'd4 - font_col];
        end
    end

endmodule

/* logic/display_pkg.sv */
package display_pkg;

    // screen position, row major
    typedef struct packed {
        logic [9:0] row;
        logic [9:0] col;
    } vga_coord_t;

    // syncs are active low, blank is high while outside the visible area
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic blank;
    } vga_sync_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    localparam rgb_t BG_COLOR = '{r: 8'h30, g: 8'h30, b: 8'h30};
    localparam rgb_t FG_COLOR = '{r: 8'hff, g: 8'hff, b: 8'hff};

endpackage

/* logic/glyph_rom.sv */
module glyph_rom (
    input  logic [7:0] code,
    input  logic [2:0] row,
    output logic [4:0] bits
);
    // seven rows of five, top row in the upper bits, leftmost pixel is bit 4
    logic [34:0] glyph;

    always_comb begin
        case (code)
            // digits
            "0": glyph = 35'b01110_10001_10011_10101_11001_10001_01110;
            "1": glyph = 35'b00100_01100_00100_00100_00100_00100_01110;
            "2": glyph = 35'b01110_10001_00001_00010_00100_01000_11111;
            "3": glyph = 35'b11111_00010_00100_00010_00001_10001_01110;
            "4": glyph = 35'b00010_00110_01010_10010_11111_00010_00010;
            "5": glyph = 35'b11111_10000_11110_00001_00001_10001_01110;
            "6": glyph = 35'b00110_01000_10000_11110_10001_10001_01110;
            "7": glyph = 35'b11111_00001_00010_00100_01000_01000_01000;
            "8": glyph = 35'b01110_10001_10001_01110_10001_10001_01110;
            "9": glyph = 35'b01110_10001_10001_01111_00001_00010_01100;

            // letters of LINES and CLEARED
            "A": glyph = 35'b01110_10001_10001_11111_10001_10001_10001;
            "C": glyph = 35'b01110_10001_10000_10000_10000_10001_01110;
            "D": glyph = 35'b11100_10010_10001_10001_10001_10010_11100;
            "E": glyph = 35'b11111_10000_10000_11110_10000_10000_11111;
            "I": glyph = 35'b01110_00100_00100_00100_00100_00100_01110;
            "L": glyph = 35'b10000_10000_10000_10000_10000_10000_11111;
            "N": glyph = 35'b10001_10001_11001_10101_10011_10001_10001;
            "R": glyph = 35'b11110_10001_10001_11110_10100_10010_10001;
            "S": glyph = 35'b01111_10000_10000_01110_00001_00001_11110;

            ":": glyph = 35'b00000_01100_01100_00000_01100_01100_00000;

            // space and anything unknown
            default: glyph = '0;
        endcase
    end

    // row 7 is past the bottom of the glyph
    always_comb begin
        case (row)
            3'd0:    bits = glyph[34:30];
            3'd1:    bits = glyph[29:25];
            3'd2:    bits = glyph[24:20];
            3'd3:    bits = glyph[19:15];
            3'd4:    bits = glyph[14:10];
            3'd5:    bits = glyph[9:5];
            3'd6:    bits = glyph[4:0];
            default: bits = '0;
        endcase
    end

endmodule

/* logic/lines_cleared_panel.sv */
`include "stat_display_cfg.svh"

module lines_cleared_panel
    import display_pkg::*,
           stats_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  vga_coord_t  coord,
    input  game_stats_t stats,
    output rgb_t        color
);
    localparam int          LEN_1     = 5;
    localparam int          LEN_2     = 8;
    localparam logic [39:0] WORD_1    = "LINES";
    localparam logic [63:0] WORD_2    = "CLEARED:";
    localparam int          TEXT_TOP  = `LC_VSTART + `LC_MARGIN;

    logic [LEN_1-1:0] lit_1;
    logic [LEN_2-1:0] lit_2;
    logic [1:0]       lit_num;
    logic [1:0]       tens;
    logic [5:0]       ones;
    logic [7:0]       tens_code;
    logic [7:0]       ones_code;
    logic             in_panel;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // label rows
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar g = 0; g < LEN_1; g++) begin : g_word_1
        char_cell #(
            .ORIGIN_ROW (10'(TEXT_TOP)),
            .ORIGIN_COL (10'(`LC_HSTART + `GLYPH_PITCH * g))
        ) u_cell (
            .coord (coord),
            .code  (WORD_1[8*(LEN_1-1-g) +: 8]),
            .lit   (lit_1[g])
        );
    end

    for (genvar g = 0; g < LEN_2; g++) begin : g_word_2
        char_cell #(
            .ORIGIN_ROW (10'(TEXT_TOP + `LINE_PITCH)),
            .ORIGIN_COL (10'(`LC_HSTART + `GLYPH_PITCH * g))
        ) u_cell (
            .coord (coord),
            .code  (WORD_2[8*(LEN_2-1-g) +: 8]),
            .lit   (lit_2[g])
        );
    end

    // count is already clamped to 39, so tens never passes 3
    always_comb begin
        tens = 2'd0;
        if (stats.lines_cleared >= 6'd30) begin
            tens = 2'd3;
        end else if (stats.lines_cleared >= 6'd20) begin
            tens = 2'd2;
        end else if (stats.lines_cleared >= 6'd10) begin
            tens = 2'd1;
        end
        ones      = stats.lines_cleared - 6'(tens) * 6'd10;
        tens_code = 8'h30 + 8'(tens);
        ones_code = 8'h30 + 8'(ones);
    end

    char_cell #(
        .ORIGIN_ROW (10'(TEXT_TOP + 2 * `LINE_PITCH)),
        .ORIGIN_COL (10'(`LC_HSTART))
    ) u_tens (.coord(coord), .code(tens_code), .lit(lit_num[1]));

    char_cell #(
        .ORIGIN_ROW (10'(TEXT_TOP + 2 * `LINE_PITCH)),
        .ORIGIN_COL (10'(`LC_HSTART + `GLYPH_PITCH))
    ) u_ones (.coord(coord), .code(ones_code), .lit(lit_num[0]));

    // panel lies inside the visible area, so outside it covers blanking too
    assign in_panel = coord.row >= 10'(`LC_VSTART) && coord.row < 10'(`LC_VEND) &&
                      coord.col >= 10'(`LC_HSTART) && coord.col < 10'(`LC_HEND);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            color <= '0;
        end else if (!in_panel) begin
            color <= '0;
        end else if ((|lit_1) || (|lit_2) || (|lit_num)) begin
            color <= FG_COLOR;
        end else begin
            color <= BG_COLOR;
        end
    end

endmodule

/* logic/stat_display_cfg.svh */
`ifndef STAT_DISPLAY_CFG_SVH
`define STAT_DISPLAY_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vga 640x480 timing, in pixel clocks and lines
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define H_ACTIVE        640
`define H_FRONT         16
`define H_SYNC          96
`define H_BACK          48
`define H_TOTAL         (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

`define V_ACTIVE        480
`define V_FRONT         10
`define V_SYNC          2
`define V_BACK          33
`define V_TOTAL         (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lines cleared panel, left of the playfield
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define LC_HSTART       32
`define LC_VSTART       200
`define LC_HEND         (`LC_HSTART + 112)
`define LC_VEND         (`LC_VSTART + 46)
`define LC_MARGIN       1

`define GLYPH_SCALE     2
`define GLYPH_PITCH     14
`define LINE_PITCH      15

`define LINES_MAX       39
`define PIXEL_LATENCY   1

`endif

/* logic/stat_display_top.sv */
module stat_display_top
    import display_pkg::*,
           stats_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  wb_req_t   wb_req,
    output wb_rsp_t   wb_rsp,
    output vga_sync_t sync,
    output rgb_t      color
);
    logic        frame_start;
    vga_coord_t  coord;
    game_stats_t stats;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // raster timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    vga_timing u_timing (
        .clk         (clk),
        .arst_n      (arst_n),
        .coord       (coord),
        .sync        (sync),
        .frame_start (frame_start)
    );

    // host registers, shadow updates once per frame
    stats_regs u_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .frame_start (frame_start),
        .stats       (stats)
    );

    lines_cleared_panel u_panel (
        .clk    (clk),
        .arst_n (arst_n),
        .coord  (coord),
        .stats  (stats),
        .color  (color)
    );

endmodule

/* logic/stats_pkg.sv */
package stats_pkg;

    // wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // values shown on screen
    typedef struct packed {
        logic [5:0] lines_cleared;
    } game_stats_t;

endpackage

/* logic/stats_regs.sv */
`include "stat_display_cfg.svh"

module stats_regs
    import stats_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  wb_req_t     wb_req,
    output wb_rsp_t     wb_rsp,
    input  logic        frame_start,
    output game_stats_t stats
);
    localparam logic [1:0] ADR_LINES  = 2'd0;
    localparam logic [1:0] ADR_FRAMES = 2'd1;

    logic [5:0]  lines_q;
    logic [31:0] frame_count;
    logic        xfer;
    logic [5:0]  wr_lines;
    logic [31:0] rd_data;

    // one ack per strobe, the slave never stalls
    assign xfer = wb_req.cyc && wb_req.stb && !wb_rsp.ack;

    // writes above the limit saturate
    always_comb begin
        if (wb_req.dat > 32'(`LINES_MAX)) begin
            wr_lines = 6'(`LINES_MAX);
        end else begin
            wr_lines = wb_req.dat[5:0];
        end
    end

    always_comb begin
        case (wb_req.adr)
            ADR_LINES:  rd_data = {26'd0, lines_q};
            ADR_FRAMES: rd_data = frame_count;
            default:    rd_data = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus response, live register, frame count and shadow
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_rsp      <= '0;
            lines_q     <= '0;
            frame_count <= '0;
            stats       <= '0;
        end else begin
            wb_rsp.ack <= xfer;
            if (xfer) begin
                wb_rsp.dat <= rd_data;
            end
            // frame counter address is read only, writes just get acked
            if (xfer && wb_req.we && wb_req.adr == ADR_LINES) begin
                lines_q <= wr_lines;
            end
            if (frame_start) begin
                frame_count         <= frame_count + 32'd1;
                stats.lines_cleared <= lines_q;
            end
        end
    end

endmodule

/* logic/vga_timing.sv */
`include "stat_display_cfg.svh"

module vga_timing
    import display_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    output vga_coord_t coord,
    output vga_sync_t  sync,
    output logic       frame_start
);
    localparam logic [9:0] H_LAST   = 10'(`H_TOTAL - 1);
    localparam logic [9:0] V_LAST   = 10'(`V_TOTAL - 1);
    localparam logic [9:0] HS_START = 10'(`H_ACTIVE + `H_FRONT);
    localparam logic [9:0] HS_END   = 10'(`H_ACTIVE + `H_FRONT + `H_SYNC);
    localparam logic [9:0] VS_START = 10'(`V_ACTIVE + `V_FRONT);
    localparam logic [9:0] VS_END   = 10'(`V_ACTIVE + `V_FRONT + `V_SYNC);

    localparam vga_sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, blank: 1'b1};

    logic [9:0] col_q;
    logic [9:0] row_q;
    logic       line_end;
    vga_sync_t  sync_raw;
    vga_sync_t  sync_dly [`PIXEL_LATENCY];

    assign line_end = (col_q == H_LAST);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pixel and line counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col_q <= '0;
            row_q <= '0;
        end else begin
            col_q <= line_end ? '0 : col_q + 10'd1;
            if (line_end) begin
                row_q <= (row_q == V_LAST) ? '0 : row_q + 10'd1;
            end
        end
    end

    assign coord       = '{row: row_q, col: col_q};
    assign frame_start = (row_q == '0) && (col_q == '0);

    // sync windows decoded from the current count
    always_comb begin
        sync_raw.hsync = !(col_q >= HS_START && col_q < HS_END);
        sync_raw.vsync = !(row_q >= VS_START && row_q < VS_END);
        sync_raw.blank = (col_q >= 10'(`H_ACTIVE)) || (row_q >= 10'(`V_ACTIVE));
    end

    // delay to line up with the registered panel colour
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `PIXEL_LATENCY; i++) begin
                sync_dly[i] <= SYNC_IDLE;
            end
        end else begin
            sync_dly[0] <= sync_raw;
            for (int i = 1; i < `PIXEL_LATENCY; i++) begin
                sync_dly[i] <= sync_dly[i-1];
            end
        end
    end

    assign sync = sync_dly[`PIXEL_LATENCY-1];

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f stat_display.f \
    --top-module stat_display_tb -o sim_stat_display

./obj_dir/sim_stat_display 2>&1 | tee sim.log

if grep -qx "Test OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi

/* stat_display.f */
+incdir+logic
logic/display_pkg.sv
logic/stats_pkg.sv
logic/vga_timing.sv
logic/stats_regs.sv
logic/glyph_rom.sv
logic/char_cell.sv
logic/lines_cleared_panel.sv
logic/stat_display_top.sv
verif/stat_display_assertions.sv
verif/stat_display_tb.sv

/* verif/stat_display_assertions.sv */
`include "stat_display_cfg.svh"

module stat_display_assertions
    import stats_pkg::*;
(
    input logic       clk,
    input logic       arst_n,
    input wb_req_t    wb_req,
    input wb_rsp_t    wb_rsp,
    input logic [5:0] lines_q
);
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // wishbone handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ack_follows_stb: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(wb_req.cyc && wb_req.stb) |=> wb_rsp.ack
    ) else $error("ack did not follow cyc and stb by one cycle");

    // no ack out of nowhere
    ack_needs_request: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(wb_rsp.ack) |-> $past(wb_req.cyc && wb_req.stb)
    ) else $error("ack rose without cyc and stb in the cycle before");

    // stored count stays clamped
    count_clamped: assert property (
        @(posedge clk) disable iff (!arst_n)
        lines_q <= 6'(`LINES_MAX)
    ) else $error("lines_cleared register above its limit");

endmodule

/* verif/stat_display_stimulus.txt */
# records: G then lit pixels of digit glyphs 0 to 9 at scale 2 (decimal)
# W value readback | F value shown for one frame | M old new, new written mid-frame
G 76 40 56 56 56 68 60 44 68 60
W 7 7
W 39 39
W 40 39
W 200 39
W 0 0
F 0
F 25
F 39
F 18
M 12 37

/* verif/stat_display_tb.sv */
`include "stat_display_cfg.svh"

module stat_display_tb
    import display_pkg::*,
           stats_pkg::*;
();
    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;
    localparam int H_TOTAL    = `H_TOTAL;
    localparam int V_TOTAL    = `V_TOTAL;
    localparam int FRAME_CYC  = H_TOTAL * V_TOTAL;
    localparam int DIGIT_ROW  = `LC_VSTART + `LC_MARGIN + 2 * `LINE_PITCH;

    logic      clk;
    logic      arst_n;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    vga_sync_t sync;
    rgb_t      color;

    int     glyph_pixels [10];
    int     wr_value [$];
    int     wr_expect [$];
    int     frame_value [$];
    int     mid_old [$];
    int     mid_new [$];
    longint watchdog_time;

    // raster position rebuilt from the syncs
    logic h_prev;
    logic v_prev;
    logic col_known;
    logic row_known;
    int   pix_col;
    int   pix_row;
    int   since_hfall;
    int   lines_since_vfall;
    int   hs_low;
    int   vs_low;
    int   hfalls;
    int   vfalls;
    int   digit_acc;
    int   digit_count;
    int   frames_done;

    stat_display_top uut (
        .clk    (clk),
        .arst_n (arst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .sync   (sync),
        .color  (color)
    );

    bind stats_regs stat_display_assertions u_wb_checks (
        .clk     (clk),
        .arst_n  (arst_n),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .lines_q (lines_q)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("ERROR at time %0t: %s", $time, why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic load_stimulus();
        int               fd;
        int               n;
        int               a;
        int               b;
        logic [63:0]      tok;
        logic [8*120-1:0] rest;
        fd = $fopen("verif/stat_display_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verif/stat_display_stimulus.txt");
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == 64'("#")) begin
                n = $fgets(rest, fd);
            end else if (tok == 64'("G")) begin
                for (int i = 0; i < 10; i++) begin
                    n = $fscanf(fd, "%d", glyph_pixels[i]);
                    if (n != 1) begin
                        abort_run("short G record in the stimulus file");
                    end
                end
            end else if (tok == 64'("W")) begin
                n = $fscanf(fd, "%d %d", a, b);
                if (n != 2) begin
                    abort_run("short W record in the stimulus file");
                end
                wr_value.push_back(a);
                wr_expect.push_back(b);
            end else if (tok == 64'("F")) begin
                n = $fscanf(fd, "%d", a);
                if (n != 1) begin
                    abort_run("short F record in the stimulus file");
                end
                frame_value.push_back(a);
            end else if (tok == 64'("M")) begin
                n = $fscanf(fd, "%d %d", a, b);
                if (n != 2) begin
                    abort_run("short M record in the stimulus file");
                end
                mid_old.push_back(a);
                mid_new.push_back(b);
            end else begin
                abort_run("unknown record kind in the stimulus file");
            end
        end
        $fclose(fd);
    endtask

    // one classic cycle, starts on a fresh clock so stb always drops in between
    task automatic wb_cycle(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(posedge clk);
        #DRIVE_DLY;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            waited++;
            if (waited > 8) begin
                abort_run("no Wishbone ack within 8 clocks");
            end
        end while (!wb_rsp.ack);
        rdat   = wb_rsp.dat;
        wb_req = '0;
        check_value("ack_latency", waited, 1);
    endtask

    task automatic check_frame_count();
        logic [31:0] rd;
        wb_cycle(1'b0, 2'd1, '0, rd);
        check_value("frame_count", rd, vfalls);
    endtask

    task automatic wait_vsync_fall();
        int seen;
        seen = vfalls;
        while (vfalls == seen) @(posedge clk);
    endtask

    task automatic wait_frame_done();
        int seen;
        seen = frames_done;
        while (frames_done == seen) @(posedge clk);
    endtask

    task automatic wait_row(input int row);
        while (!(row_known && pix_row == row)) @(posedge clk);
    endtask

    // tens and ones glyphs of a clamped count
    function automatic int digit_pixels(input int value);
        int v;
        v = (value > `LINES_MAX) ? `LINES_MAX : value;
        return glyph_pixels[v / 10] + glyph_pixels[v % 10];
    endfunction

    function automatic logic in_digit_box(input int row, input int col);
        logic in_rows;
        logic in_tens;
        logic in_ones;
        in_rows = row >= DIGIT_ROW && row < DIGIT_ROW + 7 * `GLYPH_SCALE;
        in_tens = col >= `LC_HSTART && col < `LC_HSTART + 5 * `GLYPH_SCALE;
        in_ones = col >= `LC_HSTART + `GLYPH_PITCH &&
                  col < `LC_HSTART + `GLYPH_PITCH + 5 * `GLYPH_SCALE;
        return in_rows && (in_tens || in_ones);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output monitor, sampled mid-cycle where sync and colour are settled
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (!arst_n) begin
            h_prev            = 1'b1;
            v_prev            = 1'b1;
            col_known         = 1'b0;
            row_known         = 1'b0;
            pix_col           = 0;
            pix_row           = 0;
            since_hfall       = 0;
            lines_since_vfall = 0;
            hs_low            = 0;
            vs_low            = 0;
            hfalls            = 0;
            vfalls            = 0;
            digit_acc         = 0;
            digit_count       = 0;
            frames_done       = 0;
        end else begin
            if (col_known) begin
                pix_col = (pix_col == H_TOTAL - 1) ? 0 : pix_col + 1;
                if (pix_col == 0 && row_known) begin
                    pix_row = (pix_row == V_TOTAL - 1) ? 0 : pix_row + 1;
                end
            end
            since_hfall++;
            if (!h_prev && sync.hsync) begin
                check_value("hsync_low_clocks", hs_low, `H_SYNC);
            end
            if (!v_prev && sync.vsync) begin
                check_value("vsync_low_clocks", vs_low, `V_SYNC * H_TOTAL);
            end
            hs_low = sync.hsync ? 0 : hs_low + 1;
            vs_low = sync.vsync ? 0 : vs_low + 1;
            // hsync falls at the first column of the sync window
            if (h_prev && !sync.hsync) begin
                if (hfalls > 0) begin
                    check_value("hsync_period", since_hfall, H_TOTAL);
                end
                if (col_known) begin
                    check_value("hsync_fall_col", pix_col, `H_ACTIVE + `H_FRONT);
                end
                pix_col     = `H_ACTIVE + `H_FRONT;
                col_known   = 1'b1;
                since_hfall = 0;
                hfalls++;
                lines_since_vfall++;
            end
            // vsync falls at column 0 of the first sync line
            if (v_prev && !sync.vsync) begin
                if (vfalls > 0) begin
                    check_value("vsync_period_lines", lines_since_vfall, V_TOTAL);
                end
                check_value("vsync_fall_col", pix_col, 0);
                if (row_known) begin
                    check_value("vsync_fall_row", pix_row, `V_ACTIVE + `V_FRONT);
                end
                pix_row           = `V_ACTIVE + `V_FRONT;
                row_known         = 1'b1;
                lines_since_vfall = 0;
                vfalls++;
            end
            h_prev = sync.hsync;
            v_prev = sync.vsync;
            if (col_known && row_known) begin
                // blank covers everything outside the 640x480 window
                check_value("sync_blank", sync.blank,
                            pix_col >= `H_ACTIVE || pix_row >= `V_ACTIVE);
                if (pix_row >= `LC_VSTART && pix_row < `LC_VEND &&
                    pix_col >= `LC_HSTART && pix_col < `LC_HEND) begin
                    if (pix_row == `LC_VSTART && pix_col == `LC_HSTART) begin
                        check_value("color_panel_corner", 32'(color), 32'(BG_COLOR));
                    end else begin
                        check_value("color_panel",
                                    32'(color == FG_COLOR || color == BG_COLOR), 32'd1);
                    end
                    if (color == FG_COLOR && in_digit_box(pix_row, pix_col)) begin
                        digit_acc++;
                    end
                end else begin
                    check_value("color_outside_panel", 32'(color), 32'd0);
                end
                // end of the active area closes one frame's digit count
                if (pix_row == `V_ACTIVE && pix_col == 0) begin
                    digit_count = digit_acc;
                    digit_acc   = 0;
                    frames_done++;
                end
            end
        end
    end

    initial begin
        wait (watchdog_time != 0);
        #(watchdog_time);
        abort_run("simulation timed out before all tests finished");
    end

    initial begin
        logic [31:0] rd;
        arst_n = 1'b0;
        wb_req = '0;
        load_stimulus();
        watchdog_time = longint'(frame_value.size() + 2 * mid_old.size() + 3)
                        * FRAME_CYC * CLK_PERIOD;
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;

        // register access and clamping
        foreach (wr_value[i]) begin
            wb_cycle(1'b1, 2'd0, 32'(wr_value[i]), rd);
            wb_cycle(1'b0, 2'd0, '0, rd);
            check_value("lines_cleared", rd, wr_expect[i]);
            // unmapped address must not alias the live register
            wb_cycle(1'b0, 2'd2, '0, rd);
            check_value("reg_adr_2", rd, 0);
        end

        // raster position is known from here on
        wait_vsync_fall();
        check_frame_count();

        // written in vertical blanking, shown by the next frame
        foreach (frame_value[i]) begin
            wb_cycle(1'b1, 2'd0, 32'(frame_value[i]), rd);
            wait_frame_done();
            check_value("digit_pixels", digit_count, digit_pixels(frame_value[i]));
            wait_vsync_fall();
            check_frame_count();
        end

        // a write above the digit rows must wait for the next frame
        foreach (mid_old[i]) begin
            wb_cycle(1'b1, 2'd0, 32'(mid_old[i]), rd);
            wait_row(100);
            wb_cycle(1'b1, 2'd0, 32'(mid_new[i]), rd);
            wait_frame_done();
            check_value("digit_pixels_same_frame", digit_count, digit_pixels(mid_old[i]));
            wait_frame_done();
            check_value("digit_pixels_next_frame", digit_count, digit_pixels(mid_new[i]));
            wait_vsync_fall();
            check_frame_count();
        end

        $display("Test OK");
        $finish;
    end

endmodule
